/* include/datapathDefines.svh */
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// ========================================
// datapath sizing.
// ========================================

`define DATA_WIDTH      32
`define REG_COUNT       16
`define REG_INDEX_WIDTH 4

// instruction fields.
`define OPCODE_WIDTH    5
`define IMM_WIDTH       19

`define DIV_STEPS       32 // one quotient bit per cycle.

`endif

/* rtl/datapathPkg.sv */
`include "datapathDefines.svh"

package datapathPkg;

        typedef enum logic [`OPCODE_WIDTH-1:0] {
                ldi, add, sub, andOp, orOp, mul, div, mfhi, mflo, st, halt
        } opcodeT;

        // one fetched word, seen as register or immediate format.
        typedef union packed {
                struct packed {
                        opcodeT                      opcode;
                        logic [`REG_INDEX_WIDTH-1:0] ra;
                        logic [`REG_INDEX_WIDTH-1:0] rb;
                        logic [`REG_INDEX_WIDTH-1:0] rc;
                        logic [14:0]                 unused;
                } rFormat;
                struct packed {
                        opcodeT                      opcode;
                        logic [`REG_INDEX_WIDTH-1:0] ra;
                        logic [`REG_INDEX_WIDTH-1:0] rb;
                        logic [`IMM_WIDTH-1:0]       imm;
                } iFormat;
        } instrWord;

        typedef enum logic [2:0] {
                aluAdd, aluSub, aluAnd, aluOr, aluMul, aluDiv
        } aluOpT;

        typedef struct packed {
                // bus sources.
                logic regOut, pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut, cOut;
                // bus loads.
                logic regIn, pcIn, irIn, marIn, mdrIn, yIn, zIn, hiIn, loIn;
                logic incPc, read, write;
                aluOpT aluOp;
                logic [`REG_INDEX_WIDTH-1:0] regIndex;
        } controlWord;

        typedef enum logic [2:0] {
                srcReg, srcPc, srcMdr, srcZLow, srcZHigh, srcHi, srcLo, srcImm
        } busSourceT;

endpackage

/* rtl/restoringDivider.sv */
`timescale 1ns/1ns
`include "datapathDefines.svh"

module restoringDivider (
        input  logic                   Clock,
        input  logic                   rst,
        input  logic                   start,
        input  logic [`DATA_WIDTH-1:0] dividend,
        input  logic [`DATA_WIDTH-1:0] divisor,
        output logic [`DATA_WIDTH-1:0] quotient,
        output logic [`DATA_WIDTH-1:0] remainder,
        output logic                   done
);
        logic [`DATA_WIDTH-1:0] quo;
        logic [`DATA_WIDTH-1:0] rem;
        logic [`DATA_WIDTH-1:0] den;
        logic [5:0]             count;
        logic                   busy;
        logic [`DATA_WIDTH:0]   shifted;
        logic [`DATA_WIDTH+1:0] trial;

        // shift in the next dividend bit and try the subtraction.
        assign shifted = {rem, quo[`DATA_WIDTH-1]};
        assign trial   = {1'b0, shifted} - {2'b00, den};

        always_ff @(posedge Clock) begin
                if (rst) begin
                        busy  <= 1'b0;
                        done  <= 1'b0;
                        count <= '0;
                end else begin
                        done <= busy && count == 6'd1;
                        if (start) begin
                                busy  <= 1'b1;
                                count <= 6'(`DIV_STEPS);
                        end else if (busy) begin
                                count <= count - 6'd1;
                                busy  <= count != 6'd1;
                        end
                end
        end

        always_ff @(posedge Clock) begin
                if (start) begin
                        quo <= dividend;
                        rem <= '0;
                        den <= divisor;
                end else if (busy) begin
                        if (trial[`DATA_WIDTH+1]) begin // negative, restore.
                                rem <= shifted[`DATA_WIDTH-1:0];
                                quo <= {quo[`DATA_WIDTH-2:0], 1'b0};
                        end else begin
                                rem <= trial[`DATA_WIDTH-1:0];
                                quo <= {quo[`DATA_WIDTH-2:0], 1'b1};
                        end
                end
        end

        // a zero divisor never restores, so quotient ends all ones.
        assign quotient  = quo;
        assign remainder = rem;

endmodule

/* rtl/busArbiter.sv */
`timescale 1ns/1ns
`include "datapathDefines.svh"

module busArbiter import datapathPkg::*; (
        input  controlWord             control,
        input  logic [`DATA_WIDTH-1:0] regData,
        input  logic [`DATA_WIDTH-1:0] pcData,
        input  logic [`DATA_WIDTH-1:0] mdrData,
        input  logic [`DATA_WIDTH-1:0] zLow,
        input  logic [`DATA_WIDTH-1:0] zHigh,
        input  logic [`DATA_WIDTH-1:0] hiData,
        input  logic [`DATA_WIDTH-1:0] loData,
        input  logic [`DATA_WIDTH-1:0] immData,
        output logic [`DATA_WIDTH-1:0] busData
);
        busSourceT source;
        logic      anySource;

        // fixed priority, register file first.
        always_comb begin
                anySource = 1'b1;
                if (control.regOut)        source = srcReg;
                else if (control.pcOut)    source = srcPc;
                else if (control.mdrOut)   source = srcMdr;
                else if (control.zLowOut)  source = srcZLow;
                else if (control.zHighOut) source = srcZHigh;
                else if (control.hiOut)    source = srcHi;
                else if (control.loOut)    source = srcLo;
                else begin
                        source    = srcImm;
                        anySource = control.cOut; // idle bus reads zero.
                end
        end

        always_comb begin
                case (source)
                        srcReg:   busData = regData;
                        srcPc:    busData = pcData;
                        srcMdr:   busData = mdrData;
                        srcZLow:  busData = zLow;
                        srcZHigh: busData = zHigh;
                        srcHi:    busData = hiData;
                        srcLo:    busData = loData;
                        default:  busData = anySource ? immData : '0;
                endcase
        end

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ns
`include "datapathDefines.svh"

module registerFile import datapathPkg::*; (
        input  logic                   Clock,
        input  logic                   rst,
        input  controlWord             control,
        input  logic [`DATA_WIDTH-1:0] busData,
        output logic [`DATA_WIDTH-1:0] regData,
        output logic [`DATA_WIDTH-1:0] hiData,
        output logic [`DATA_WIDTH-1:0] loData
);
        logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
        logic [`DATA_WIDTH-1:0] hiReg;
        logic [`DATA_WIDTH-1:0] loReg;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                        hiReg <= '0;
                        loReg <= '0;
                end else begin
                        if (control.regIn) begin
                                regs[control.regIndex] <= busData;
                        end
                        if (control.hiIn) begin
                                hiReg <= busData;
                        end
                        if (control.loIn) begin
                                loReg <= busData;
                        end
                end
        end

        assign regData = regs[control.regIndex]; // same index for read and write.
        assign hiData  = hiReg;
        assign loData  = loReg;

endmodule

/* rtl/memoryInterface.sv */
`timescale 1ns/1ns
`include "datapathDefines.svh"

module memoryInterface import datapathPkg::*; (
        input  logic                   Clock,
        input  logic                   rst,
        input  controlWord             control,
        input  logic [`DATA_WIDTH-1:0] busData,
        input  logic [`DATA_WIDTH-1:0] memReadData,
        output logic [`DATA_WIDTH-1:0] mdrData,
        output logic [`DATA_WIDTH-1:0] memAddress,
        output logic [`DATA_WIDTH-1:0] memWriteData,
        output logic                   memRead,
        output logic                   memWrite
);
        logic [`DATA_WIDTH-1:0] mar;
        logic [`DATA_WIDTH-1:0] mdr;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        mar <= '0;
                        mdr <= '0;
                end else begin
                        if (control.marIn) begin
                                mar <= busData;
                        end
                        if (control.mdrIn) begin
                                mdr <= control.read ? memReadData : busData;
                        end
                end
        end

        // memory answers at mar in the same cycle.
        assign memAddress   = mar;
        assign memRead      = control.read;
        assign memWrite     = control.write;
        assign memWriteData = mdr;
        assign mdrData      = mdr;

endmodule

/* rtl/arithmeticUnit.sv */
`timescale 1ns/1ns
`include "datapathDefines.svh"

module arithmeticUnit import datapathPkg::*; (
        input  logic                   Clock,
        input  logic                   rst,
        input  controlWord             control,
        input  logic [`DATA_WIDTH-1:0] busData,
        output logic [`DATA_WIDTH-1:0] zLow,
        output logic [`DATA_WIDTH-1:0] zHigh,
        output logic                   divDone
);
        logic [`DATA_WIDTH-1:0]   y;
        logic [2*`DATA_WIDTH-1:0] z;
        logic [2*`DATA_WIDTH-1:0] aluResult;
        logic [`DATA_WIDTH-1:0]   quotient;
        logic [`DATA_WIDTH-1:0]   remainder;
        logic                     divStart;

        // ========================================
        // combinational ops, Y against the bus.
        // ========================================

        always_comb begin
                case (control.aluOp)
                        aluAdd:  aluResult = {{`DATA_WIDTH{1'b0}}, y + busData};
                        aluSub:  aluResult = {{`DATA_WIDTH{1'b0}}, y - busData};
                        aluAnd:  aluResult = {{`DATA_WIDTH{1'b0}}, y & busData};
                        aluOr:   aluResult = {{`DATA_WIDTH{1'b0}}, y | busData};
                        aluMul:  aluResult = y * busData; // full 64-bit product.
                        default: aluResult = '0;
                endcase
        end

        assign divStart = control.zIn && control.aluOp == aluDiv;

        restoringDivider i_divider (
                .Clock     (Clock),
                .rst       (rst),
                .start     (divStart),
                .dividend  (y),
                .divisor   (busData),
                .quotient  (quotient),
                .remainder (remainder),
                .done      (divDone)
        );

        // ========================================
        // Y and Z registers.
        // ========================================

        always_ff @(posedge Clock) begin
                if (control.yIn) begin
                        y <= busData;
                end
                if (divDone) begin
                        z <= {remainder, quotient}; // remainder to HI, quotient to LO.
                end else if (control.zIn && !divStart) begin
                        z <= aluResult;
                end
        end

        assign zLow  = z[`DATA_WIDTH-1:0];
        assign zHigh = z[2*`DATA_WIDTH-1:`DATA_WIDTH];

endmodule

/* rtl/controlSequencer.sv */
`timescale 1ns/1ns
`include "datapathDefines.svh"

module controlSequencer import datapathPkg::*; (
        input  logic                   Clock,
        input  logic                   rst,
        input  logic                   start,
        input  logic [`DATA_WIDTH-1:0] busData,
        input  logic                   divDone,
        output controlWord             control,
        output logic [`DATA_WIDTH-1:0] pcData,
        output logic [`DATA_WIDTH-1:0] immData,
        output logic                   halted
);
        logic [`DATA_WIDTH-1:0] pc;
        instrWord               ir;
        logic [2:0]             step;
        logic                   running;
        logic                   divWait;
        logic                   lastStep;
        logic                   advance;
        logic                   haltNow;
        aluOpT                  aluSel;

        assign pcData  = pc;
        assign immData = {{(`DATA_WIDTH-`IMM_WIDTH){ir.iFormat.imm[`IMM_WIDTH-1]}},
                          ir.iFormat.imm};

        always_comb begin
                case (ir.rFormat.opcode)
                        sub:     aluSel = aluSub;
                        andOp:   aluSel = aluAnd;
                        orOp:    aluSel = aluOr;
                        mul:     aluSel = aluMul;
                        div:     aluSel = aluDiv;
                        default: aluSel = aluAdd;
                endcase
        end

        // ========================================
        // step decode into one control word.
        // ========================================

        always_comb begin
                control  = '0;
                lastStep = 1'b0;
                advance  = 1'b1;
                haltNow  = 1'b0;
                if (running) begin
                        case (step)
                        3'd0: begin // fetch.
                                control.pcOut = 1'b1;
                                control.marIn = 1'b1;
                                control.incPc = 1'b1;
                        end
                        3'd1: begin
                                control.read  = 1'b1;
                                control.mdrIn = 1'b1;
                        end
                        3'd2: begin
                                control.mdrOut = 1'b1;
                                control.irIn   = 1'b1;
                        end
                        default: begin
                                case (ir.rFormat.opcode)
                                ldi, mfhi, mflo: begin
                                        control.cOut     = ir.rFormat.opcode == ldi;
                                        control.hiOut    = ir.rFormat.opcode == mfhi;
                                        control.loOut    = ir.rFormat.opcode == mflo;
                                        control.regIn    = 1'b1;
                                        control.regIndex = ir.iFormat.ra;
                                        lastStep         = 1'b1;
                                end
                                add, sub, andOp, orOp, mul, div: begin
                                        control.aluOp = aluSel;
                                        case (step)
                                        3'd3: begin // ra into Y.
                                                control.regOut   = 1'b1;
                                                control.regIndex = ir.rFormat.ra;
                                                control.yIn      = 1'b1;
                                        end
                                        3'd4: begin
                                                control.regOut   = 1'b1;
                                                control.regIndex = ir.rFormat.rb;
                                                control.zIn      = !divWait;
                                                if (aluSel == aluDiv) begin
                                                        advance = divWait && divDone;
                                                end
                                        end
                                        3'd5: begin
                                                control.zLowOut  = 1'b1;
                                                control.regIndex = ir.rFormat.rc;
                                                if (aluSel == aluMul || aluSel == aluDiv) begin
                                                        control.loIn = 1'b1;
                                                end else begin
                                                        control.regIn = 1'b1;
                                                        lastStep      = 1'b1;
                                                end
                                        end
                                        default: begin
                                                control.zHighOut = 1'b1;
                                                control.hiIn     = 1'b1;
                                                lastStep         = 1'b1;
                                        end
                                        endcase
                                end
                                st: begin
                                        control.regIndex = ir.iFormat.ra;
                                        if (step == 3'd3) begin // address from immediate.
                                                control.cOut  = 1'b1;
                                                control.marIn = 1'b1;
                                        end else if (step == 3'd4) begin
                                                control.regOut = 1'b1;
                                                control.mdrIn  = 1'b1;
                                        end else begin
                                                control.write = 1'b1;
                                                lastStep      = 1'b1;
                                        end
                                end
                                halt:    haltNow  = 1'b1;
                                default: lastStep = 1'b1; // unknown opcode.
                                endcase
                        end
                        endcase
                end
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        pc      <= '0;
                        step    <= '0;
                        running <= 1'b0;
                        divWait <= 1'b0;
                        halted  <= 1'b0;
                end else if (start) begin
                        pc      <= '0;
                        step    <= '0;
                        running <= 1'b1;
                        divWait <= 1'b0;
                        halted  <= 1'b0;
                end else if (running) begin
                        if (control.incPc) begin
                                pc <= pc + 1'b1;
                        end
                        if (haltNow) begin
                                running <= 1'b0;
                                halted  <= 1'b1;
                                step    <= '0;
                        end else if (advance) begin
                                step <= lastStep ? 3'd0 : step + 3'd1;
                        end
                        if (control.zIn && control.aluOp == aluDiv) begin
                                divWait <= 1'b1; // hold in T4 until the divider finishes.
                        end else if (divDone) begin
                                divWait <= 1'b0;
                        end
                end
        end

        always_ff @(posedge Clock) begin
                if (control.irIn) begin
                        ir <= busData;
                end
        end

endmodule

/* rtl/cpuDatapath.sv */
`timescale 1ns/1ns
`include "datapathDefines.svh"

module cpuDatapath import datapathPkg::*; (
        input  logic                   Clock,
        input  logic                   rst,
        input  logic                   start,
        input  logic [`DATA_WIDTH-1:0] memReadData,
        output logic [`DATA_WIDTH-1:0] memAddress,
        output logic [`DATA_WIDTH-1:0] memWriteData,
        output logic                   memRead,
        output logic                   memWrite,
        output logic                   halted
);
        controlWord             control;
        logic [`DATA_WIDTH-1:0] busData;
        logic [`DATA_WIDTH-1:0] regData, hiData, loData;
        logic [`DATA_WIDTH-1:0] mdrData;
        logic [`DATA_WIDTH-1:0] zLow, zHigh;
        logic [`DATA_WIDTH-1:0] pcData, immData;
        logic                   divDone;

        controlSequencer i_sequencer (
                .Clock (Clock), .rst (rst), .start (start), .busData (busData),
                .divDone (divDone), .control (control), .pcData (pcData),
                .immData (immData), .halted (halted)
        );

        busArbiter i_arbiter (
                .control (control), .regData (regData), .pcData (pcData),
                .mdrData (mdrData), .zLow (zLow), .zHigh (zHigh), .hiData (hiData),
                .loData (loData), .immData (immData), .busData (busData)
        );

        registerFile i_registers (
                .Clock (Clock), .rst (rst), .control (control), .busData (busData),
                .regData (regData), .hiData (hiData), .loData (loData)
        );

        memoryInterface i_memory (
                .Clock (Clock), .rst (rst), .control (control), .busData (busData),
                .memReadData (memReadData), .mdrData (mdrData), .memAddress (memAddress),
                .memWriteData (memWriteData), .memRead (memRead), .memWrite (memWrite)
        );

        arithmeticUnit i_alu (
                .Clock (Clock), .rst (rst), .control (control), .busData (busData),
                .zLow (zLow), .zHigh (zHigh), .divDone (divDone)
        );

endmodule

/* testbench/datapathTb.sv */
`timescale 1ns/1ns
`include "datapathDefines.svh"

module datapathTb import datapathPkg::*; ();

        logic                   Clock = 1'b0;
        logic                   rst;
        logic                   start;
        logic [`DATA_WIDTH-1:0] memReadData;
        logic [`DATA_WIDTH-1:0] memAddress;
        logic [`DATA_WIDTH-1:0] memWriteData;
        logic                   memRead;
        logic                   memWrite;
        logic                   halted;

        logic [`DATA_WIDTH-1:0] mem [256];
        logic [`DATA_WIDTH-1:0] programWords [$];
        string                  storeNames [$];
        logic [`DATA_WIDTH-1:0] expAddr [$];
        logic [`DATA_WIDTH-1:0] expData [$];
        int                     storeAddress = 'h80; // data region above the program.
        int                     storeIndex   = 0;
        int                     checkCount   = 0;
        int                     errorCount   = 0;
        longint                 timeoutCycles;
        logic                   programReady = 1'b0;

        cpuDatapath i_dut (
                .Clock (Clock), .rst (rst), .start (start), .memReadData (memReadData),
                .memAddress (memAddress), .memWriteData (memWriteData),
                .memRead (memRead), .memWrite (memWrite), .halted (halted)
        );

        always #50 Clock = ~Clock;

        // memory answers at once while read is high.
        assign memReadData = memRead ? mem[memAddress[7:0]] : '0;

        // ========================================
        // program building.
        // ========================================

        task automatic emitLdi(input int ra, input logic [18:0] imm);
                programWords.push_back({ldi, 4'(ra), 4'd0, imm});
        endtask

        task automatic emitAlu(input opcodeT op, input int ra, input int rb, input int rc);
                programWords.push_back({op, 4'(ra), 4'(rb), 4'(rc), 15'd0});
        endtask

        task automatic emitMove(input opcodeT op, input int ra);
                programWords.push_back({op, 4'(ra), 4'd0, 4'd0, 15'd0});
        endtask

        task automatic emitStore(input int ra, input string name);
                programWords.push_back({st, 4'(ra), 4'd0, 19'(storeAddress)});
                storeNames.push_back(name);
                storeAddress++;
        endtask

        // quotient lands in LO, remainder in HI.
        task automatic emitDivide(input int ra, input int rb, input string name);
                emitAlu(div, ra, rb, 0);
                emitMove(mfhi, 13);
                emitMove(mflo, 14);
                emitStore(13, {name, " remainder"});
                emitStore(14, {name, " quotient"});
        endtask

        function automatic logic [18:0] randomImm();
                return 19'($urandom);
        endfunction

        task automatic buildProgram();
                logic [18:0] posImm;
                logic [18:0] negImm;

                posImm     = randomImm();
                posImm[18] = 1'b0;
                negImm     = randomImm();
                negImm[18] = 1'b1;
                emitLdi(1, posImm);
                emitStore(1, "ldi positive");
                emitLdi(2, negImm);
                emitStore(2, "ldi negative");

                emitLdi(3, randomImm());
                emitLdi(4, randomImm());
                emitAlu(mul, 3, 4, 0);
                emitMove(mflo, 5);
                emitMove(mfhi, 6);
                emitStore(5, "mul lo");
                emitStore(6, "mul hi");

                // r8 gets a full width value for the logic ops.
                emitLdi(7, randomImm());
                emitAlu(mul, 5, 7, 0);
                emitMove(mflo, 8);
                emitAlu(add, 5, 8, 9);
                emitAlu(sub, 5, 8, 10);
                emitAlu(andOp, 5, 8, 11);
                emitAlu(orOp, 5, 8, 12);
                emitStore(9, "add");
                emitStore(10, "sub");
                emitStore(11, "and");
                emitStore(12, "or");

                emitLdi(2, 19'h22);
                emitLdi(6, 19'h24);
                emitDivide(2, 6, "div 0x22/0x24");
                emitDivide(5, 8, "div random");
                emitLdi(7, 19'($urandom_range(255, 1)));
                emitDivide(9, 7, "div small divisor");
                emitLdi(15, 19'd0);
                emitDivide(5, 15, "div by zero");

                emitMove(halt, 0);
                emitStore(1, "after halt"); // must never execute.
        endtask

        // ========================================
        // reference interpreter.
        // ========================================

        function automatic void runReference();
                logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
                logic [`DATA_WIDTH-1:0] hi;
                logic [`DATA_WIDTH-1:0] lo;
                logic [`DATA_WIDTH-1:0] a;
                logic [`DATA_WIDTH-1:0] b;
                logic [`DATA_WIDTH-1:0] imm;
                logic [63:0]            prod;
                logic [31:0]            w;
                logic [4:0]             op;
                int                     pc;
                bit                     stopped;

                foreach (regs[i]) regs[i] = '0;
                hi      = '0;
                lo      = '0;
                pc      = 0;
                stopped = 1'b0;
                while (!stopped && pc < programWords.size()) begin
                        w   = programWords[pc];
                        pc  = pc + 1;
                        op  = w[31:27];
                        a   = regs[w[26:23]];
                        b   = regs[w[22:19]];
                        imm = {{13{w[18]}}, w[18:0]};
                        case (op)
                                ldi:   regs[w[26:23]] = imm;
                                add:   regs[w[18:15]] = a + b;
                                sub:   regs[w[18:15]] = a - b;
                                andOp: regs[w[18:15]] = a & b;
                                orOp:  regs[w[18:15]] = a | b;
                                mul: begin
                                        prod = {32'd0, a} * {32'd0, b};
                                        lo   = prod[31:0];
                                        hi   = prod[63:32];
                                end
                                div: begin
                                        lo = (b == 0) ? '1 : a / b;
                                        hi = (b == 0) ? a : a % b;
                                end
                                mfhi:  regs[w[26:23]] = hi;
                                mflo:  regs[w[26:23]] = lo;
                                st: begin
                                        expAddr.push_back(imm);
                                        expData.push_back(a);
                                end
                                halt:    stopped = 1'b1;
                                default: ;
                        endcase
                end
        endfunction

        // ========================================
        // checking.
        // ========================================

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                checkCount++;
                assert (expected === actual) else begin
                        errorCount++;
                        $display("Fail %s expected %h actual %h", name, expected, actual);
                end
        endtask

        always @(negedge Clock) begin
                if (!rst && memWrite) begin
                        checkCount++;
                        assert (storeIndex < expAddr.size()) else begin
                                errorCount++;
                                $display("unexpected extra store to address %h", memAddress);
                        end
                        if (storeIndex < expAddr.size()) begin
                                checkValue({storeNames[storeIndex], " address"},
                                           expAddr[storeIndex], memAddress);
                                checkValue({storeNames[storeIndex], " data"},
                                           expData[storeIndex], memWriteData);
                        end
                        mem[memAddress[7:0]] = memWriteData;
                        storeIndex++;
                end
        end

        initial begin
                wait (programReady);
                #(timeoutCycles * 100);
                $display("the run timed out after %0d cycles without finishing", timeoutCycles);
                $display("*** FAILED ***");
                $finish;
        end

        initial begin
                int run;

                rst   = 1'b1;
                start = 1'b0;
                void'($urandom(58));
                buildProgram();
                runReference();
                foreach (mem[i]) mem[i] = {24'hA5A5A5, 8'(i)};
                foreach (programWords[i]) mem[i] = programWords[i];
                timeoutCycles = 2 * programWords.size() * 50 + 64;
                programReady  = 1'b1;

                repeat (16) @(posedge Clock);
                #5 rst = 1'b0;
                repeat (3) @(negedge Clock);
                checkValue("reset memRead", 0, memRead);
                checkValue("reset memWrite", 0, memWrite);
                checkValue("reset halted", 0, halted);

                // second run must repeat every store from address zero.
                for (run = 0; run < 2; run++) begin
                        storeIndex = 0;
                        @(posedge Clock);
                        #5 start = 1'b1;
                        @(posedge Clock);
                        #5 start = 1'b0;
                        wait (halted);
                        repeat (20) @(posedge Clock);
                        checkValue($sformatf("halted run %0d", run), 1, halted);
                        checkValue($sformatf("store count run %0d", run),
                                   expAddr.size(), storeIndex);
                end

                $display("checks %0d, errors %0d", checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

/* files.f */
+incdir+include
rtl/datapathPkg.sv
rtl/restoringDivider.sv
rtl/busArbiter.sv
rtl/registerFile.sv
rtl/memoryInterface.sv
rtl/arithmeticUnit.sv
rtl/controlSequencer.sv
rtl/cpuDatapath.sv
testbench/datapathTb.sv
